//--- common/gmii_rx_pkg.sv
////////////////////////////////////////
// shared types and sizes for the GMII
// receive front end. every RTL block
// pulls these in by a wildcard import
// in its module header.
////////////////////////////////////////

package gmii_rx_pkg;

    ////////////////////////////////////////
    // data widths
    ////////////////////////////////////////

    typedef logic [7:0]  byte_t;       // one GMII byte
    typedef logic [8:0]  fifo_word_t;  // {boundary flag, byte}
    typedef logic [15:0] frame_cnt_t;  // delivered frame count

    ////////////////////////////////////////
    // FIFO sizing
    ////////////////////////////////////////

    localparam int FIFO_DEPTH = 16;
    localparam int FIFO_AW    = 4;     // pointer bits, count is one wider

    ////////////////////////////////////////
    // writer FSM
    ////////////////////////////////////////

    // WR_FULL_ERR keeps pushing the rest of a frame after an overflow
    // so that the closing flagged word still goes out
    typedef enum logic [1:0] {
        WR_IDLE     = 2'b00,  // wait for dv
        WR_TRANS    = 2'b01,  // copy bytes
        WR_FULL_ERR = 2'b10   // drain after full
    } writer_state_t;

endpackage

//--- gmii_rx_writer/gmii_rx_writer.sv
////////////////////////////////////////
// GMII receive writer. samples the PHY
// side, turns each frame into 9-bit FIFO
// words with the boundary flag on the
// first and last byte, and pulses
// o_fifo_overflow when the FIFO is full.
////////////////////////////////////////

`timescale 1ns/1ns

module gmii_rx_writer
    import gmii_rx_pkg::*;
(
    input  logic       i_gmii_rxclk,
    input  logic       reset_n,
    // GMII side
    input  logic       i_gmii_dv,
    input  byte_t      i_gmii_rxd,
    input  logic       i_gmii_er,
    // FIFO write side
    input  logic       i_fifo_full,
    output fifo_word_t o_fifo_word,
    output logic       o_fifo_wr,
    // status
    output logic       o_gmii_er,
    output logic       o_fifo_overflow
);

    writer_state_t state;
    logic          r_gmii_dv;    // dv one cycle back
    byte_t         r_gmii_rxd;   // data one cycle back
    logic          r_start;      // next word opens a frame
    logic          last_byte;    // registered byte is the frame's last

    assign o_gmii_er = i_gmii_er;  // not acted on here

    ////////////////////////////////////////
    // input sampling
    ////////////////////////////////////////

    always_ff @(posedge i_gmii_rxclk or negedge reset_n) begin
        if (!reset_n) begin
            r_gmii_dv <= 1'b0;
        end else begin
            r_gmii_dv <= i_gmii_dv;
        end
    end

    always_ff @(posedge i_gmii_rxclk) begin
        r_gmii_rxd <= i_gmii_rxd;
    end

    // dv fell between the registered and the live sample
    assign last_byte = r_gmii_dv & ~i_gmii_dv;

    ////////////////////////////////////////
    // framing FSM
    ////////////////////////////////////////

    always_ff @(posedge i_gmii_rxclk or negedge reset_n) begin
        if (!reset_n) begin
            state           <= WR_IDLE;
            r_start         <= 1'b0;
            o_fifo_word     <= '0;
            o_fifo_wr       <= 1'b0;
            o_fifo_overflow <= 1'b0;
        end else begin
            case (state)
                WR_IDLE: begin
                    if (i_gmii_dv) begin
                        // first byte only gets registered this cycle
                        o_fifo_wr       <= 1'b0;
                        o_fifo_overflow <= 1'b0;
                        r_start         <= 1'b1;
                        state           <= WR_TRANS;
                    end else begin
                        r_start         <= 1'b0;
                        o_fifo_overflow <= i_fifo_full;
                        o_fifo_wr       <= i_fifo_full;   // flagged zero word on full
                        o_fifo_word     <= {i_fifo_full, 8'h00};
                    end
                end
                WR_TRANS: begin
                    r_start   <= 1'b0;   // start flag lives one cycle
                    o_fifo_wr <= 1'b1;
                    if (!i_fifo_full) begin
                        o_fifo_overflow <= 1'b0;
                        o_fifo_word     <= {r_start | last_byte, r_gmii_rxd};
                        if (last_byte) begin
                            state <= WR_IDLE;
                        end
                    end else begin
                        o_fifo_overflow <= 1'b1;
                        o_fifo_word     <= {last_byte, r_gmii_rxd};
                        state           <= last_byte ? WR_IDLE : WR_FULL_ERR;
                    end
                end
                WR_FULL_ERR: begin
                    r_start         <= 1'b0;
                    o_fifo_overflow <= 1'b0;
                    o_fifo_wr       <= 1'b1;
                    // keep pushing, close the frame when dv drops
                    o_fifo_word     <= {~i_gmii_dv, r_gmii_rxd};
                    if (!i_gmii_dv) begin
                        state <= WR_IDLE;
                    end
                end
                default: begin
                    r_start         <= 1'b0;
                    o_fifo_wr       <= 1'b0;
                    o_fifo_overflow <= 1'b0;
                    o_fifo_word     <= '0;
                    state           <= WR_IDLE;
                end
            endcase
        end
    end

endmodule

//--- verilog/rx_byte_fifo.sv
////////////////////////////////////////
// synchronous 9-bit FIFO between the
// GMII writer and the frame reader.
// the head word shows combinationally
// on o_rd_word, writes while full are
// dropped.
////////////////////////////////////////

`timescale 1ns/1ns

module rx_byte_fifo
    import gmii_rx_pkg::*;
(
    input  logic       i_gmii_rxclk,
    input  logic       reset_n,
    input  fifo_word_t i_wr_word,
    input  logic       i_wr_en,
    input  logic       i_rd_en,
    output fifo_word_t o_rd_word,
    output logic       o_full,
    output logic       o_empty
);

    fifo_word_t         mem [FIFO_DEPTH];
    logic [FIFO_AW-1:0] wr_ptr;
    logic [FIFO_AW-1:0] rd_ptr;
    logic [FIFO_AW:0]   count;     // 0 .. FIFO_DEPTH
    logic               do_wr;
    logic               do_rd;

    assign do_wr = i_wr_en & ~o_full;    // full drops the word
    assign do_rd = i_rd_en & ~o_empty;

    assign o_full    = (count == (FIFO_AW+1)'(FIFO_DEPTH));
    assign o_empty   = (count == '0);
    assign o_rd_word = mem[rd_ptr];

    // storage
    always_ff @(posedge i_gmii_rxclk) begin
        if (do_wr) begin
            mem[wr_ptr] <= i_wr_word;
        end
    end

    ////////////////////////////////////////
    // pointers and occupancy
    ////////////////////////////////////////

    always_ff @(posedge i_gmii_rxclk or negedge reset_n) begin
        if (!reset_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= wr_ptr + 1'b1;   // wraps at depth
            end
            if (do_rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;   // both or neither
            endcase
        end
    end

endmodule

//--- verilog/rx_frame_reader.sv
////////////////////////////////////////
// frame reader. pops FIFO words while
// the consumer is ready, turns the
// boundary flag into sof and eof, and
// counts complete frames.
////////////////////////////////////////

`timescale 1ns/1ns

module rx_frame_reader
    import gmii_rx_pkg::*;
(
    input  logic       i_gmii_rxclk,
    input  logic       reset_n,
    input  fifo_word_t i_fifo_word,
    input  logic       i_fifo_empty,
    input  logic       i_rx_ready,
    output logic       o_fifo_rd,
    output byte_t      o_rx_data,
    output logic       o_rx_valid,
    output logic       o_rx_sof,
    output logic       o_rx_eof,
    output frame_cnt_t o_frame_cnt
);

    logic in_frame;   // between an opening and a closing flag
    logic flag;

    assign flag      = i_fifo_word[8];
    assign o_fifo_rd = ~i_fifo_empty & i_rx_ready;

    // payload byte, qualified by o_rx_valid
    always_ff @(posedge i_gmii_rxclk) begin
        if (o_fifo_rd) begin
            o_rx_data <= i_fifo_word[7:0];
        end
    end

    ////////////////////////////////////////
    // flag decode and frame count
    ////////////////////////////////////////

    always_ff @(posedge i_gmii_rxclk or negedge reset_n) begin
        if (!reset_n) begin
            in_frame    <= 1'b0;
            o_rx_valid  <= 1'b0;
            o_rx_sof    <= 1'b0;
            o_rx_eof    <= 1'b0;
            o_frame_cnt <= '0;
        end else begin
            o_rx_valid <= o_fifo_rd;     // one cycle per popped word
            if (o_fifo_rd) begin
                // a flag opens a frame when outside one, closes it otherwise
                o_rx_sof <= flag & ~in_frame;
                o_rx_eof <= flag & in_frame;
                if (flag) begin
                    in_frame <= ~in_frame;
                end
                if (flag && in_frame) begin
                    o_frame_cnt <= o_frame_cnt + 1'b1;
                end
            end else begin
                o_rx_sof <= 1'b0;
                o_rx_eof <= 1'b0;
            end
        end
    end

endmodule

//--- verilog/gmii_rx_top.sv
////////////////////////////////////////
// GMII receive front end. chains the
// writer, the byte FIFO and the frame
// reader in the i_gmii_rxclk domain.
////////////////////////////////////////

`timescale 1ns/1ns

module gmii_rx_top
    import gmii_rx_pkg::*;
(
    input  logic       i_gmii_rxclk,
    input  logic       reset_n,
    input  logic       i_gmii_dv,
    input  byte_t      i_gmii_rxd,
    input  logic       i_gmii_er,
    input  logic       i_rx_ready,
    output logic       o_gmii_er,
    output logic       o_fifo_overflow,
    output byte_t      o_rx_data,
    output logic       o_rx_valid,
    output logic       o_rx_sof,
    output logic       o_rx_eof,
    output frame_cnt_t o_frame_cnt
);

    fifo_word_t wr_word;
    logic       wr_en;
    logic       fifo_full;
    fifo_word_t rd_word;
    logic       rd_en;
    logic       fifo_empty;

    gmii_rx_writer gmii_rx_writer_i (
        .i_gmii_rxclk    (i_gmii_rxclk),
        .reset_n         (reset_n),
        .i_gmii_dv       (i_gmii_dv),
        .i_gmii_rxd      (i_gmii_rxd),
        .i_gmii_er       (i_gmii_er),
        .i_fifo_full     (fifo_full),
        .o_fifo_word     (wr_word),
        .o_fifo_wr       (wr_en),
        .o_gmii_er       (o_gmii_er),
        .o_fifo_overflow (o_fifo_overflow)
    );

    rx_byte_fifo rx_byte_fifo_i (
        .i_gmii_rxclk (i_gmii_rxclk),
        .reset_n      (reset_n),
        .i_wr_word    (wr_word),
        .i_wr_en      (wr_en),
        .i_rd_en      (rd_en),
        .o_rd_word    (rd_word),
        .o_full       (fifo_full),
        .o_empty      (fifo_empty)
    );

    rx_frame_reader rx_frame_reader_i (
        .i_gmii_rxclk (i_gmii_rxclk),
        .reset_n      (reset_n),
        .i_fifo_word  (rd_word),
        .i_fifo_empty (fifo_empty),
        .i_rx_ready   (i_rx_ready),
        .o_fifo_rd    (rd_en),
        .o_rx_data    (o_rx_data),
        .o_rx_valid   (o_rx_valid),
        .o_rx_sof     (o_rx_sof),
        .o_rx_eof     (o_rx_eof),
        .o_frame_cnt  (o_frame_cnt)
    );

endmodule

//--- bench/gmii_rx_sva.sv
////////////////////////////////////////
// concurrent checks on the GMII receive
// top level. bound into gmii_rx_top from
// the testbench, also sees the FIFO
// write strobe and full level
////////////////////////////////////////

`timescale 1ns/1ns

module gmii_rx_sva
    import gmii_rx_pkg::*;
(
    input logic i_gmii_rxclk,
    input logic reset_n,
    input logic i_gmii_er,
    input logic i_rx_ready,
    input logic i_er_out,     // o_gmii_er
    input logic i_overflow,   // o_fifo_overflow
    input logic i_rx_valid,
    input logic i_rx_sof,
    input logic i_rx_eof,
    input logic i_fifo_full,
    input logic i_fifo_wr
);

    // outputs quiet while reset is held
    reset_quiet: assert property (@(posedge i_gmii_rxclk)
        !reset_n |-> (!i_rx_valid && !i_overflow))
        else $error("valid or overflow high during reset");

    flags_need_valid: assert property (@(posedge i_gmii_rxclk) disable iff (!reset_n)
        (i_rx_sof || i_rx_eof) |-> i_rx_valid)
        else $error("sof or eof without valid");

    sof_eof_apart: assert property (@(posedge i_gmii_rxclk) disable iff (!reset_n)
        !(i_rx_sof && i_rx_eof))
        else $error("sof and eof in the same cycle");

    valid_after_ready: assert property (@(posedge i_gmii_rxclk) disable iff (!reset_n)
        i_rx_valid |-> $past(i_rx_ready))
        else $error("valid after an edge with ready low");

    er_follows: assert property (@(posedge i_gmii_rxclk)
        i_er_out == i_gmii_er)
        else $error("gmii_er not passed through");

    // first dropped write gets flagged one cycle later
    overflow_flag: assert property (@(posedge i_gmii_rxclk) disable iff (!reset_n)
        $rose(i_fifo_wr && i_fifo_full) |=> i_overflow)
        else $error("write dropped on full without overflow pulse");

endmodule

//--- bench/gmii_rx_tb.sv
////////////////////////////////////////
// testbench for the GMII receive front
// end. sends random frames, holds the
// consumer back to overrun the FIFO, then
// stalls it periodically, and checks the
// output stream against a scoreboard
////////////////////////////////////////

`timescale 1ns/1ns

module gmii_rx_tb
    import gmii_rx_pkg::*;
();

    localparam int NUM_INTACT = 12;
    localparam int NUM_STALL  = 8;
    localparam int GAP        = 3;                  // idle cycles between frames
    localparam int OVF_LEN    = FIFO_DEPTH + 8;     // longest frame that overruns the FIFO
    localparam int NUM_FRAMES = NUM_INTACT + NUM_STALL + 1;
    localparam int WATCHDOG   = NUM_FRAMES * (OVF_LEN + GAP) * 4 + 200;

    logic       i_gmii_rxclk;
    logic       reset_n;
    logic       i_gmii_dv;
    byte_t      i_gmii_rxd;
    logic       i_gmii_er;
    logic       i_rx_ready;
    logic       o_gmii_er;
    logic       o_fifo_overflow;
    byte_t      o_rx_data;
    logic       o_rx_valid;
    logic       o_rx_sof;
    logic       o_rx_eof;
    frame_cnt_t o_frame_cnt;

    logic [9:0]  exp_q [$];                 // {sof, eof, byte}
    logic [31:0] rng_state = 32'h09b1_468e;
    string       test_name = "reset";
    int          errors;
    int          frames_done;
    int          ovf_cycles;
    int          cyc;
    int          ready_mode;                // 0 ready, 1 held low, 2 periodic stall
    logic        ready_at_edge;             // i_rx_ready seen at the last rising edge
    logic        drop_last;                 // FIFO write dropped in the previous cycle
    logic        drop_rose;                 // dropped writes began in the previous cycle

    gmii_rx_top gmii_rx_top_i (
        .i_gmii_rxclk    (i_gmii_rxclk),
        .reset_n         (reset_n),
        .i_gmii_dv       (i_gmii_dv),
        .i_gmii_rxd      (i_gmii_rxd),
        .i_gmii_er       (i_gmii_er),
        .i_rx_ready      (i_rx_ready),
        .o_gmii_er       (o_gmii_er),
        .o_fifo_overflow (o_fifo_overflow),
        .o_rx_data       (o_rx_data),
        .o_rx_valid      (o_rx_valid),
        .o_rx_sof        (o_rx_sof),
        .o_rx_eof        (o_rx_eof),
        .o_frame_cnt     (o_frame_cnt)
    );

    bind gmii_rx_top gmii_rx_sva gmii_rx_sva_i (
        .i_gmii_rxclk (i_gmii_rxclk),
        .reset_n      (reset_n),
        .i_gmii_er    (i_gmii_er),
        .i_rx_ready   (i_rx_ready),
        .i_er_out     (o_gmii_er),
        .i_overflow   (o_fifo_overflow),
        .i_rx_valid   (o_rx_valid),
        .i_rx_sof     (o_rx_sof),
        .i_rx_eof     (o_rx_eof),
        .i_fifo_full  (fifo_full),
        .i_fifo_wr    (wr_en)
    );

    initial begin
        i_gmii_rxclk = 1'b0;
        forever #2 i_gmii_rxclk = ~i_gmii_rxclk;
    end

    function automatic logic [31:0] next_rand();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    task automatic show_mismatch(input string what, input logic [15:0] want,
                                 input logic [15:0] got);
        errors++;
        $display("ERR %s %s: expected %h actual %h", test_name, what, want, got);
    endtask

    task automatic raise_fault(input string msg);
        errors++;
        $display("error in %s at %0t ns: %s", test_name, $time, msg);
    endtask

    // one clock with inputs moved 1 ns after the edge
    task automatic step();
        @(posedge i_gmii_rxclk);
        #1;
        cyc++;
        case (ready_mode)
            0:       i_rx_ready = 1'b1;
            1:       i_rx_ready = 1'b0;
            default: i_rx_ready = (cyc % 8 != 0);   // one stall cycle in eight
        endcase
    endtask

    // only the first keep bytes are expected back
    task automatic send_frame(input int len, input int keep);
        logic [31:0] r;
        byte_t       b;
        for (int i = 0; i < len; i++) begin
            step();
            r          = next_rand();
            b          = r[23:16];
            i_gmii_dv  = 1'b1;
            i_gmii_rxd = b;
            i_gmii_er  = r[5];
            if (i < keep) begin
                exp_q.push_back({i == 0, i == len - 1, b});
            end
        end
        repeat (GAP) begin
            step();
            i_gmii_dv  = 1'b0;
            i_gmii_rxd = '0;
            i_gmii_er  = 1'b0;
        end
    endtask

    task automatic drain();
        while (exp_q.size() != 0) begin
            step();
        end
        repeat (4) step();
    endtask

    ////////////////////////////////////////
    // output monitor and scoreboard
    ////////////////////////////////////////

    always @(posedge i_gmii_rxclk) begin
        ready_at_edge <= i_rx_ready;
    end

    always @(negedge i_gmii_rxclk) begin
        logic [9:0] want;
        logic       dropping;
        dropping = gmii_rx_top_i.wr_en && gmii_rx_top_i.fifo_full;
        if (!reset_n) begin
            assert (!o_rx_valid && !o_fifo_overflow)
                else raise_fault("valid or overflow high during reset");
        end
        assert (o_gmii_er == i_gmii_er)
            else show_mismatch("gmii_er", 16'(i_gmii_er), 16'(o_gmii_er));
        assert (o_rx_valid || !(o_rx_sof || o_rx_eof))
            else raise_fault("sof or eof without valid");
        assert (!(o_rx_sof && o_rx_eof)) else raise_fault("sof and eof together");
        assert (!o_rx_valid || ready_at_edge)
            else raise_fault("valid after an edge with ready low");
        // the first dropped write is answered by an overflow pulse
        if (drop_rose) begin
            assert (o_fifo_overflow)
                else raise_fault("write dropped on full without overflow pulse");
        end
        drop_rose = reset_n && dropping && !drop_last;
        drop_last = dropping;
        if (o_fifo_overflow) begin
            ovf_cycles++;
        end
        if (o_rx_valid) begin
            if (exp_q.size() == 0) begin
                raise_fault("output byte while nothing was expected");
            end else begin
                want = exp_q.pop_front();
                assert (o_rx_data == want[7:0])
                    else show_mismatch("data", 16'(want[7:0]), 16'(o_rx_data));
                assert ({o_rx_sof, o_rx_eof} == want[9:8])
                    else show_mismatch("sof/eof", 16'(want[9:8]), 16'({o_rx_sof, o_rx_eof}));
            end
            if (o_rx_eof) begin
                frames_done++;
                assert (o_frame_cnt == 16'(frames_done))
                    else show_mismatch("frame_cnt", 16'(frames_done), o_frame_cnt);
            end
        end
    end

    ////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////

    initial begin
        int len;
        reset_n       = 1'b1;
        i_gmii_dv     = 1'b0;
        i_gmii_rxd    = '0;
        i_gmii_er     = 1'b0;
        i_rx_ready    = 1'b1;
        ready_at_edge = 1'b1;
        drop_last     = 1'b0;
        drop_rose     = 1'b0;
        #1 reset_n = 1'b0;
        repeat (10) step();
        reset_n = 1'b1;

        test_name = "intact";
        for (int f = 0; f < NUM_INTACT; f++) begin
            len = 2 + int'(next_rand() >> 16) % 11;   // 2 .. 12 bytes
            send_frame(len, len);
        end
        drain();

        // consumer held off so the cut frame is closed by a flagged zero word
        test_name  = "overflow";
        ready_mode = 1;
        send_frame(OVF_LEN, FIFO_DEPTH);
        exp_q.push_back({1'b0, 1'b1, 8'h00});
        repeat (4) step();
        ready_mode = 0;
        drain();

        test_name  = "stall";
        ready_mode = 2;
        for (int f = 0; f < NUM_STALL; f++) begin
            len = 2 + int'(next_rand() >> 16) % 11;
            send_frame(len, len);
        end
        ready_mode = 0;
        drain();

        test_name = "summary";
        assert (ovf_cycles > 0) else raise_fault("o_fifo_overflow never pulsed");
        assert (frames_done == NUM_FRAMES)
            else show_mismatch("frames", 16'(NUM_FRAMES), 16'(frames_done));
        $display("errors: %0d, frames checked: %0d, overflow cycles: %0d",
                 errors, frames_done, ovf_cycles);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

    // watchdog
    initial begin
        repeat (WATCHDOG) @(posedge i_gmii_rxclk);
        $display("timeout: run not done after %0d cycles, errors: %0d", WATCHDOG, errors);
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule

//--- project.f
common/gmii_rx_pkg.sv
gmii_rx_writer/gmii_rx_writer.sv
verilog/rx_byte_fifo.sv
verilog/rx_frame_reader.sv
verilog/gmii_rx_top.sv
bench/gmii_rx_sva.sv
bench/gmii_rx_tb.sv

//--- Makefile
# Verilator build and run for the GMII receive front end

TOP       ?= gmii_rx_tb
FILELIST  ?= project.f
LOG       ?= sim.log
OBJ_DIR   ?= obj_dir
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
SIM_ARGS  ?= +verilator+error+limit+100

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR) -o V$(TOP)

run: compile
	./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "SIMULATION FAILED" $(LOG); then echo "failure reported in $(LOG)"; exit 1; fi
	@grep -q "SIMULATION PASSED" $(LOG) || { echo "run ended without a result in $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)
